/* line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module line_buffer
	import spu_pkg::*;
(
	input  logic               clk,
	input  logic               line_start,
	input  logic               line_sel,
	input  logic               pix_we,
	input  logic [LBUF_AW-1:0] pix_wa,
	input  logic [PIX_W:0]     pix_wd,
	output logic [PIX_W-1:0]   pix_color,
	output logic               pix_valid
);

	typedef enum logic [1:0] {
		rd_settle,	// address stable
		rd_show,	// latch pixel, request clear
		rd_clear,	// clear write happens
		rd_step	// next address
	} rd_phase_t;

	logic [PIX_W:0] buf0 [LINE_PIXELS];	// {opaque, colour}
	logic [PIX_W:0] buf1 [LINE_PIXELS];

	rd_phase_t          phase;
	logic [LBUF_AW-1:0] rd_addr;
	logic               clr_we;
	logic               done;
	logic [PIX_W:0]     rd_data;

	logic               we0, we1;
	logic [LBUF_AW-1:0] wa0, wa1;
	logic [PIX_W:0]     wd0, wd1;

	assign done    = (rd_addr >= LBUF_AW'(LINE_PIXELS));
	assign rd_data = line_sel ? buf0[rd_addr] : buf1[rd_addr];	// half not being drawn

	// ------------------------------
	// write ports, engine or clear
	// ------------------------------
	assign we0 = line_sel ? clr_we : pix_we;
	assign wa0 = line_sel ? rd_addr : pix_wa;
	assign wd0 = line_sel ? '0 : pix_wd;
	assign we1 = line_sel ? pix_we : clr_we;
	assign wa1 = line_sel ? pix_wa : rd_addr;
	assign wd1 = line_sel ? pix_wd : '0;

	always_ff @(posedge clk)
	begin
		if (we0)
			buf0[wa0] <= wd0;
		if (we1)
			buf1[wa1] <= wd1;
	end

	// ------------------------------
	// readout, four clocks a pixel
	// ------------------------------
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			phase     <= rd_settle;
			rd_addr   <= '0;
			clr_we    <= 1'b0;
			pix_color <= '0;
			pix_valid <= 1'b0;
		end
		else
		begin
			clr_we <= 1'b0;
			case (phase)
				rd_settle:
					phase <= rd_show;	// line_sel swaps on this clock
				rd_show:
				begin
					pix_valid <= !done && rd_data[PIX_W];
					pix_color <= done ? '0 : rd_data[PIX_W-1:0];
					clr_we    <= !done;	// empty after shown
					phase     <= rd_clear;
				end
				rd_clear:
					phase <= rd_step;
				rd_step:
				begin
					if (!done)
						rd_addr <= rd_addr + 1'b1;
					phase <= rd_settle;
				end
				default:
					phase <= rd_settle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the sprite unit testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv \
	-f sprite_unit.f \
	--top-module tb_sprite_unit \
	-Mdir obj_dir -o sim_sprite_unit
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_sprite_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0

/* sprite_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_engine
	import spu_pkg::*, spu_mem_pkg::*;
#(
	parameter int NUM_SPRITES = 32
)
(
	input  logic                           clk,
	input  logic                           line_start,
	input  logic [VLINE_W-1:0]             vline,
	input  logic [ATTR_W-1:0]              attr_rd,
	input  logic [PIX_W:0]                 pal_rd,
	input  logic [OFFS_W-1:0]              offs_rd,
	input  logic [DATA_W-1:0]              mem_data,
	input  logic                           mem_strobe,
	output logic [$clog2(NUM_SPRITES)+2:0] attr_ra,
	output logic [PAL_AW-1:0]              pal_ra,
	output logic [$clog2(NUM_SPRITES)-1:0] offs_ra,
	output logic [OFFS_W-1:0]              offs_wd,
	output logic                           offs_we,
	output logic                           mem_req,
	output logic [ADDR_W-1:0]              mem_addr,
	output logic                           pix_we,
	output logic [LBUF_AW-1:0]             pix_wa,
	output logic [PIX_W:0]                 pix_wd,
	output logic                           busy
);

	localparam int SPR_W = $clog2(NUM_SPRITES);

	engine_state_t     state;
	logic [SPR_W-1:0]  num;	// sprite in work
	color_mode_t       cmode;
	logic [5:0]        pal;	// palette select from reg4
	logic [7:0]        ypos_lo;
	logic [ADDR_W-1:0] base;	// image base, words
	logic [OFFS_W-1:0] offs;	// current row offset
	logic [7:0]        words_left;
	logic [2:0]        pix_left;	// pixels still in the word
	logic [LBUF_AW-1:0] wa;	// buffer write position
	logic [DATA_W-1:0] sh;	// pixel word shifter

	logic [SPR_W-1:0]   num_next;
	logic [VLINE_W-1:0] ypos_full;
	logic [VLINE_W:0]   ypos_end;
	logic               vis;
	color_mode_t        mode_rd;
	logic [7:0]         xsz_words;
	logic [OFFS_W-1:0]  offs_next;
	logic [ADDR_W-1:0]  word_addr;
	logic               px_opaque;
	logic [PIX_W-1:0]   px_color;

	assign num_next  = num + 1'b1;
	assign ypos_full = {attr_rd[7], ypos_lo};	// valid in attr_ysize
	assign ypos_end  = {1'b0, ypos_full} + {1'b0, attr_rd[6:0], 2'b00};	// 4 lines per unit
	assign vis       = (vline >= ypos_full) && ({1'b0, vline} < ypos_end);
	assign mode_rd   = color_mode_t'(attr_rd[1:0]);
	assign xsz_words = (cmode == cm_direct) ? {attr_rd[6:0], 1'b0} : {1'b0, attr_rd[6:0]};
	assign offs_next = offs + 1'b1;
	assign word_addr = base + ADDR_W'(offs);

	// direct colour from the shifter, else through the palette
	assign px_opaque = (cmode == cm_direct) ? sh[DATA_W-1] : !pal_rd[PIX_W];
	assign px_color  = (cmode == cm_direct) ? sh[DATA_W-3 -: PIX_W] : pal_rd[PIX_W-1:0];

	// palette address of the pixel at the top of w
	function automatic logic [PAL_AW-1:0] pal_addr(input logic [DATA_W-1:0] w);
		if (cmode == cm_c4)
			return {pal, w[DATA_W-1 -: 2]};
		return {pal[5:2], w[DATA_W-1 -: 4]};	// 16c drops low palette bits
	endfunction

	function automatic logic [DATA_W-1:0] shift_px(input logic [DATA_W-1:0] w);
		case (cmode)
			cm_c4:   return w << 2;
			cm_c16:  return w << 4;
			default: return w << 8;	// direct, one byte per pixel
		endcase
	endfunction

	// ------------------------------
	// descriptor walk and pixel loop
	// ------------------------------
	always_ff @(posedge clk or posedge line_start)
	begin : fsm
		logic advance;	// sprite done or skipped
		advance = 1'b0;
		if (line_start)
		begin
			state      <= idle_scan;
			num        <= '0;
			cmode      <= cm_off;
			pal        <= '0;
			ypos_lo    <= '0;
			base       <= '0;
			offs       <= '0;
			words_left <= '0;
			pix_left   <= '0;
			wa         <= '0;
			sh         <= '0;
			attr_ra    <= '0;
			pal_ra     <= '0;
			offs_ra    <= '0;
			offs_wd    <= '0;
			offs_we    <= 1'b0;
			mem_req    <= 1'b0;
			mem_addr   <= '0;
			pix_we     <= 1'b0;
			pix_wa     <= '0;
			pix_wd     <= '0;
			busy       <= 1'b0;
		end
		else
		begin
			offs_we <= 1'b0;
			pix_we  <= 1'b0;
			case (state)
				idle_scan:
				begin
					num     <= '0;
					attr_ra <= {SPR_W'(0), ATTR_REG_MODE};
					offs_ra <= '0;
					busy    <= 1'b1;
					state   <= attr_mode;
				end
				attr_mode:
				begin
					if (mode_rd != cm_off)
					begin
						cmode        <= mode_rd;
						pal          <= attr_rd[7:2];
						attr_ra[2:0] <= ATTR_REG_YPOS_L;
						state        <= attr_ypos;
					end
					else
						advance = 1'b1;	// inactive
				end
				attr_ypos:
				begin
					ypos_lo      <= attr_rd;
					attr_ra[2:0] <= ATTR_REG_YPOS_H;
					state        <= attr_ysize;
				end
				attr_ysize:
				begin
					if (vis)
					begin
						offs         <= (vline == ypos_full) ? '0 : offs_rd;	// first line restarts
						attr_ra[2:0] <= ATTR_REG_ADR0;
						state        <= attr_adr0;
					end
					else
						advance = 1'b1;	// not on this line
				end
				attr_adr0:
				begin
					base[7:0]    <= attr_rd;
					attr_ra[2:0] <= ATTR_REG_ADR1;
					state        <= attr_adr1;
				end
				attr_adr1:
				begin
					base[15:8]   <= attr_rd;
					attr_ra[2:0] <= ATTR_REG_ADR2;
					state        <= attr_adr2;
				end
				attr_adr2:
				begin
					base[ADDR_W-1:16] <= attr_rd[ADDR_W-17:0];
					attr_ra[2:0]      <= ATTR_REG_XPOS_L;
					state             <= attr_xpos;
				end
				attr_xpos:
				begin
					wa[7:0]      <= attr_rd;
					attr_ra[2:0] <= ATTR_REG_XPOS_H;
					state        <= attr_xsize;
				end
				attr_xsize:
				begin
					wa[8] <= attr_rd[7];
					if (xsz_words == 8'd0)
						advance = 1'b1;	// empty row
					else
					begin
						words_left <= xsz_words;
						mem_addr   <= word_addr;	// first word of the row
						mem_req    <= 1'b1;
						offs       <= offs_next;
						offs_wd    <= offs_next;
						offs_we    <= 1'b1;
						state      <= wait_word;
					end
				end
				wait_word:
				begin
					if (mem_strobe)
					begin
						mem_req    <= 1'b0;	// idle while the word is unpacked
						words_left <= words_left - 1'b1;
						if (words_left != 8'd1)
						begin
							mem_addr <= word_addr;	// next word ready
							offs     <= offs_next;
							offs_wd  <= offs_next;
							offs_we  <= 1'b1;
						end
						pal_ra <= pal_addr(mem_data);	// pixel 0 lookup
						sh     <= (cmode == cm_direct) ? mem_data : shift_px(mem_data);
						case (cmode)
							cm_c4:   pix_left <= 3'd7;
							cm_c16:  pix_left <= 3'd3;
							default: pix_left <= 3'd1;
						endcase
						state <= emit_pixels;
					end
				end
				emit_pixels:
				begin
					pix_we   <= px_opaque;	// transparent leaves buffer alone
					pix_wa   <= wa;
					pix_wd   <= {1'b1, px_color};
					wa       <= wa + 1'b1;
					pal_ra   <= pal_addr(sh);
					sh       <= shift_px(sh);
					pix_left <= pix_left - 1'b1;
					if (pix_left == 3'd0)
						state <= end_word;
				end
				end_word:
				begin
					if (words_left != 8'd0)
					begin
						mem_req <= 1'b1;
						state   <= wait_word;
					end
					else
						advance = 1'b1;
				end
				halt:
					busy <= 1'b0;	// wait for next line_start
				default:
					state <= halt;
			endcase

			if (advance)
			begin
				if (&num)	// last sprite
				begin
					busy  <= 1'b0;
					state <= halt;
				end
				else
				begin
					num     <= num_next;
					attr_ra <= {num_next, ATTR_REG_MODE};
					offs_ra <= num_next;
					state   <= attr_mode;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* sprite_tables.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_tables
	import spu_pkg::*, spu_mem_pkg::*;
#(
	parameter int NUM_SPRITES = 32
)
(
	input  logic                           clk,
	input  logic                           line_start,
	input  logic                           pre_vline,
	input  logic                           cfg_we,
	input  logic [PAL_AW:0]                cfg_addr,
	input  logic [ATTR_W-1:0]              cfg_data,
	input  logic [$clog2(NUM_SPRITES)+2:0] attr_ra,
	input  logic [PAL_AW-1:0]              pal_ra,
	input  logic [$clog2(NUM_SPRITES)-1:0] offs_ra,
	input  logic [OFFS_W-1:0]              offs_wd,
	input  logic                           offs_we,
	output logic [ATTR_W-1:0]              attr_rd,
	output logic [PIX_W:0]                 pal_rd,
	output logic [OFFS_W-1:0]              offs_rd,
	output logic [VLINE_W-1:0]             vline,
	output logic                           line_sel
);

	localparam int ATTR_AW = $clog2(NUM_SPRITES) + 3;

	logic [ATTR_W-1:0] attr_mem [NUM_SPRITES*8];	// 8 regs per sprite
	logic [PIX_W:0]    pal_mem  [2**PAL_AW];	// bit6 transparent
	logic [OFFS_W-1:0] offs_mem [NUM_SPRITES];	// row offset per sprite

	logic fresh;	// set by line_start, gone after first clock
	logic line_step;

	// ------------------------------
	// host writes and offset update
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (cfg_we && cfg_addr[PAL_AW])
			pal_mem[cfg_addr[PAL_AW-1:0]] <= cfg_data[PIX_W:0];
		if (cfg_we && !cfg_addr[PAL_AW])
			attr_mem[cfg_addr[ATTR_AW-1:0]] <= cfg_data;	// sprite*8 + reg
		if (offs_we)
			offs_mem[offs_ra] <= offs_wd;	// engine writes back offs+1
	end

	// addresses come registered from the engine
	assign attr_rd = attr_mem[attr_ra];
	assign pal_rd  = pal_mem[pal_ra];
	assign offs_rd = offs_mem[offs_ra];

	// ------------------------------
	// line counter
	// ------------------------------
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
			fresh <= 1'b1;
		else
			fresh <= 1'b0;
	end

	assign line_step = fresh && !line_start;	// first clock after line_start falls

	always_ff @(posedge clk)
	begin
		if (line_step)
		begin
			if (pre_vline || vline == VLINE_W'(VLINES - 1))
				vline <= '0;	// frame restart
			else
				vline <= vline + 1'b1;
			line_sel <= ~line_sel;	// swap buffer halves
		end
	end

endmodule

`default_nettype wire

/* sprite_unit.f */
spu_pkg.sv
spu_mem_pkg.sv
sprite_tables.sv
sprite_engine.sv
line_buffer.sv
sprite_unit.sv
sprite_unit_properties.sv
tb_sprite_unit.sv

/* sprite_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_unit
	import spu_pkg::*, spu_mem_pkg::*;
#(
	parameter int NUM_SPRITES = 32
)
(
	input  logic              clk,
	input  logic              line_start,	// also async reset
	input  logic              pre_vline,
	input  logic              cfg_we,
	input  logic [PAL_AW:0]   cfg_addr,	// bit8 palette
	input  logic [ATTR_W-1:0] cfg_data,
	output logic              mem_req,
	output logic [ADDR_W-1:0] mem_addr,
	input  logic [DATA_W-1:0] mem_data,
	input  logic              mem_strobe,
	output logic [PIX_W-1:0]  pix_color,
	output logic              pix_valid,
	output logic              busy
);

	localparam int SPR_W = $clog2(NUM_SPRITES);

	// ------------------------------
	// table side
	// ------------------------------
	logic [SPR_W+2:0]     attr_ra;
	logic [ATTR_W-1:0]    attr_rd;
	logic [PAL_AW-1:0]    pal_ra;
	logic [PIX_W:0]       pal_rd;
	logic [SPR_W-1:0]     offs_ra;
	logic [OFFS_W-1:0]    offs_wd, offs_rd;
	logic                 offs_we;
	logic [VLINE_W-1:0]   vline;
	logic                 line_sel;

	// engine to buffer
	logic                 pix_we;
	logic [LBUF_AW-1:0]   pix_wa;
	logic [PIX_W:0]       pix_wd;

	sprite_tables #(
		.NUM_SPRITES (NUM_SPRITES)
	) sprite_tables_inst (
		.clk        (clk),
		.line_start (line_start),
		.pre_vline  (pre_vline),
		.cfg_we     (cfg_we),
		.cfg_addr   (cfg_addr),
		.cfg_data   (cfg_data),
		.attr_ra    (attr_ra),
		.pal_ra     (pal_ra),
		.offs_ra    (offs_ra),
		.offs_wd    (offs_wd),
		.offs_we    (offs_we),
		.attr_rd    (attr_rd),
		.pal_rd     (pal_rd),
		.offs_rd    (offs_rd),
		.vline      (vline),
		.line_sel   (line_sel)
	);

	sprite_engine #(
		.NUM_SPRITES (NUM_SPRITES)
	) sprite_engine_inst (
		.clk        (clk),
		.line_start (line_start),
		.vline      (vline),
		.attr_rd    (attr_rd),
		.pal_rd     (pal_rd),
		.offs_rd    (offs_rd),
		.mem_data   (mem_data),
		.mem_strobe (mem_strobe),
		.attr_ra    (attr_ra),
		.pal_ra     (pal_ra),
		.offs_ra    (offs_ra),
		.offs_wd    (offs_wd),
		.offs_we    (offs_we),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.pix_we     (pix_we),
		.pix_wa     (pix_wa),
		.pix_wd     (pix_wd),
		.busy       (busy)
	);

	line_buffer line_buffer_inst (
		.clk        (clk),
		.line_start (line_start),
		.line_sel   (line_sel),
		.pix_we     (pix_we),
		.pix_wa     (pix_wa),
		.pix_wd     (pix_wd),
		.pix_color  (pix_color),
		.pix_valid  (pix_valid)
	);

endmodule

`default_nettype wire

/* sprite_unit_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_unit_properties
	import spu_pkg::*, spu_mem_pkg::*;
(
	input logic              clk,
	input logic              line_start,
	input logic              mem_req,
	input logic [ADDR_W-1:0] mem_addr,
	input logic              mem_strobe,
	input logic              pix_we,
	input logic              busy,
	input engine_state_t     state
);

	// address held until the word arrives
	addr_hold: assert property (@(posedge clk) disable iff (line_start)
		mem_req && !mem_strobe |=> $stable(mem_addr))
		else $error("mem_addr moved while a request was open");

	// line_start doubles as reset
	quiet_in_reset: assert property (@(posedge clk)
		line_start |-> !mem_req && !pix_we)
		else $error("mem_req or pix_we high during line_start");

	// busy covers the whole walk, low before it starts and once halted
	busy_tracks_walk: assert property (@(posedge clk) disable iff (line_start)
		busy == !(state inside {idle_scan, halt}))
		else $error("busy does not match the engine state");

endmodule

bind sprite_engine sprite_unit_properties props_inst (
	.clk        (clk),
	.line_start (line_start),
	.mem_req    (mem_req),
	.mem_addr   (mem_addr),
	.mem_strobe (mem_strobe),
	.pix_we     (pix_we),
	.busy       (busy),
	.state      (state)
);

`default_nettype wire

/* spu_mem_pkg.sv */
`default_nettype none

package spu_mem_pkg;

	localparam int ADDR_W = 21;	// word address, 2M x 16
	localparam int DATA_W = 16;
	localparam int OFFS_W = 16;	// row offset in words
	localparam int ATTR_W = 8;	// descriptor register width
	localparam int PAL_AW = 8;	// 256 palette entries

	// descriptor register index inside an 8 byte block
	localparam logic [2:0] ATTR_REG_XPOS_L = 3'd0;
	localparam logic [2:0] ATTR_REG_XPOS_H = 3'd1;	// bit7 xpos[8], 6..0 xsize
	localparam logic [2:0] ATTR_REG_YPOS_L = 3'd2;
	localparam logic [2:0] ATTR_REG_YPOS_H = 3'd3;	// bit7 ypos[8], 6..0 ysize
	localparam logic [2:0] ATTR_REG_MODE   = 3'd4;	// 7..2 palette, 1..0 mode
	localparam logic [2:0] ATTR_REG_ADR0   = 3'd5;
	localparam logic [2:0] ATTR_REG_ADR1   = 3'd6;
	localparam logic [2:0] ATTR_REG_ADR2   = 3'd7;	// bits 4..0 only

	// mode bits of reg4
	typedef enum logic [1:0] {
		cm_off    = 2'd0,
		cm_c4     = 2'd1,
		cm_c16    = 2'd2,
		cm_direct = 2'd3
	} color_mode_t;

endpackage

`default_nettype wire

/* spu_pkg.sv */
`default_nettype none

package spu_pkg;

	// ------------------------------
	// raster
	// ------------------------------
	localparam int LINE_PIXELS = 360;	// visible pixels per line
	localparam int LBUF_AW     = 9;	// line buffer address bits
	localparam int VLINES      = 288;	// lines per frame
	localparam int VLINE_W     = 9;	// line counter bits

	localparam int PIX_W = 6;	// colour index width

	// ------------------------------
	// engine FSM
	// ------------------------------
	typedef enum logic [3:0] {
		idle_scan,	// line begin, point at sprite 0
		attr_mode,	// reg4: mode and palette
		attr_ypos,	// reg2
		attr_ysize,	// reg3, visibility test
		attr_adr0,
		attr_adr1,
		attr_adr2,
		attr_xpos,	// reg0
		attr_xsize,	// reg1, first fetch
		wait_word,	// waiting for mem_strobe
		emit_pixels,	// one pixel per clock
		end_word,
		halt	// all sprites done
	} engine_state_t;

endpackage

`default_nettype wire

/* tb_sprite_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sprite_unit
	import spu_pkg::*, spu_mem_pkg::*;
();

	localparam int NSPR      = 32;
	localparam int NLINES    = 24;
	localparam int RESTART_N = 14;	// line with pre_vline
	localparam int IMG_WORDS = 1024;

	logic              clk = 1'b0;
	logic              line_start;
	logic              pre_vline;
	logic              cfg_we;
	logic [PAL_AW:0]   cfg_addr;
	logic [ATTR_W-1:0] cfg_data;
	logic              mem_req;
	logic [ADDR_W-1:0] mem_addr;
	logic [DATA_W-1:0] mem_data;
	logic              mem_strobe;
	logic [PIX_W-1:0]  pix_color;
	logic              pix_valid;
	logic              busy;

	// model state
	logic [7:0]        attr [NSPR][8];
	logic [PIX_W:0]    pal [256];	// bit6 transparent
	logic [DATA_W-1:0] img [IMG_WORDS];
	logic [OFFS_W-1:0] moffs [NSPR];
	logic [PIX_W:0]    cur_line [LINE_PIXELS];	// {opaque, colour}
	logic [PIX_W:0]    prev_line [LINE_PIXELS];
	logic [ADDR_W-1:0] exp_addr [$];	// word fetches still due

	int   errors = 0;
	int   checks = 0;
	int   tests = 0;
	int   mem_wait = 0;
	logic addr_en = 1'b0;
	logic req_prev = 1'b0;
	logic hung = 1'b0;	// engine stuck busy, stop the line loop

	sprite_unit #(
		.NUM_SPRITES (NSPR)
	) sprite_unit_inst (
		.clk        (clk),
		.line_start (line_start),
		.pre_vline  (pre_vline),
		.cfg_we     (cfg_we),
		.cfg_addr   (cfg_addr),
		.cfg_data   (cfg_data),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data),
		.mem_strobe (mem_strobe),
		.pix_color  (pix_color),
		.pix_valid  (pix_valid),
		.busy       (busy)
	);

	always #5 clk = ~clk;

	// image word, upper address bits folded in
	function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
		return img[a[9:0]] ^ {a[20:10], 5'b10101};
	endfunction

	// ------------------------------
	// checks
	// ------------------------------
	task automatic compare_pixel(input int k, input logic got_v,
		input logic [PIX_W-1:0] got_c, input logic [PIX_W:0] expd);
		checks++;
		if (got_v !== expd[PIX_W] || got_c !== expd[PIX_W-1:0])
		begin
			errors++;
			$display("[ERROR] %0t pixel %0d got valid %0b colour %0d, expected valid %0b colour %0d",
				$time, k, got_v, got_c, expd[PIX_W], expd[PIX_W-1:0]);
		end
	endtask

	task automatic compare_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] expd);
		checks++;
		if (got !== expd)
		begin
			errors++;
			$display("[ERROR] %0t mem_addr %0h, expected %0h", $time, got, expd);
		end
	endtask

	// ------------------------------
	// reference model of one line
	// ------------------------------
	task automatic render_line(input int v);
		int                ypos, ysize, xpos, nwords, ppw, nx;
		logic [1:0]        mode;
		logic [5:0]        psel;
		logic [ADDR_W-1:0] base;
		logic [OFFS_W-1:0] off;
		logic [DATA_W-1:0] w;
		logic [PIX_W:0]    e;
		logic [7:0]        b;
		for (int i = 0; i < LINE_PIXELS; i++)
			cur_line[i] = '0;
		for (int s = 0; s < NSPR; s++)	// ascending, higher number on top
		begin
			mode  = attr[s][4][1:0];
			psel  = attr[s][4][7:2];
			ypos  = int'({attr[s][3][7], attr[s][2]});
			ysize = int'(attr[s][3][6:0]);
			if (mode == 2'd0 || v < ypos || v >= ypos + 4 * ysize)
				continue;
			off    = (v == ypos) ? '0 : moffs[s];	// first line restarts
			base   = {attr[s][7][4:0], attr[s][6], attr[s][5]};
			xpos   = int'({attr[s][1][7], attr[s][0]});
			nwords = int'(attr[s][1][6:0]);
			if (mode == 2'd3)
				nwords = nwords * 2;
			ppw = (mode == 2'd1) ? 8 : (mode == 2'd2) ? 4 : 2;
			nx  = xpos;
			for (int k = 0; k < nwords; k++)
			begin
				exp_addr.push_back(base + ADDR_W'(off));
				w   = mem_word(base + ADDR_W'(off));
				off = off + 1'b1;
				for (int p = 0; p < ppw; p++)
				begin
					if (mode == 2'd3)
					begin
						b = w[15-8*p -: 8];	// high byte first
						if (b[7])
							cur_line[nx] = {1'b1, b[5:0]};
					end
					else
					begin
						if (mode == 2'd1)
							e = pal[{psel, w[15-2*p -: 2]}];
						else
							e = pal[{psel[5:2], w[15-4*p -: 4]}];
						if (!e[6])
							cur_line[nx] = {1'b1, e[5:0]};
					end
					nx++;
				end
			end
			if (nwords > 0)
				moffs[s] = off;
		end
	endtask

	// random scene, every 4th sprite active
	task automatic build_scene();
		logic [8:0]  xp, yp;
		logic [6:0]  xs, ys;
		logic [20:0] ba;
		logic [1:0]  md;
		for (int i = 0; i < IMG_WORDS; i++)
			img[i] = 16'($urandom);
		for (int i = 0; i < 256; i++)
			pal[i] = 7'($urandom);
		for (int s = 0; s < NSPR; s++)
		begin
			xp = 9'(20 + $urandom % 80);	// narrow band, overlaps likely
			yp = 9'(3 + $urandom % 10);
			xs = 7'(1 + $urandom % 4);
			ys = 7'(1 + $urandom % 2);
			ba = 21'($urandom);
			md = (s % 4 == 1) ? 2'(1 + $urandom % 3) : 2'd0;
			attr[s][0] = xp[7:0];
			attr[s][1] = {xp[8], xs};
			attr[s][2] = yp[7:0];
			attr[s][3] = {yp[8], ys};
			attr[s][4] = {6'($urandom), md};
			attr[s][5] = ba[7:0];
			attr[s][6] = ba[15:8];
			attr[s][7] = {3'b000, ba[20:16]};
			moffs[s]   = '0;
		end
	endtask

	task automatic cfg_write(input logic [PAL_AW:0] a, input logic [ATTR_W-1:0] d);
		@(posedge clk);
		cfg_we   <= 1'b1;
		cfg_addr <= a;
		cfg_data <= d;
	endtask

	task automatic wait_idle(input int n);
		int tmo;
		tmo = 0;
		while (busy && tmo < 2000)
		begin
			@(posedge clk);
			tmo++;
		end
		if (busy)
		begin
			$display("timeout: engine still busy at the end of line %0d", n);
			errors++;
			hung = 1'b1;
		end
	endtask

	// ------------------------------
	// memory model, 1 to 6 cycles
	// ------------------------------
	always @(posedge clk)
	begin
		if (line_start)
		begin
			mem_wait   <= 0;
			mem_strobe <= 1'b0;
		end
		else if (mem_strobe)
			mem_strobe <= 1'b0;
		else if (mem_wait > 0)
		begin
			if (mem_wait == 1)
			begin
				mem_strobe <= 1'b1;
				mem_data   <= mem_word(mem_addr);
			end
			mem_wait <= mem_wait - 1;
		end
		else if (mem_req)
			mem_wait <= 1 + int'($urandom % 6);
	end

	// each new request against the model's fetch order
	always @(posedge clk)
	begin
		req_prev <= mem_req;
		if (mem_req && !req_prev && addr_en)
		begin
			if (exp_addr.size() == 0)
			begin
				errors++;
				$display("[ERROR] %0t unexpected memory request at %0h", $time, mem_addr);
			end
			else
				compare_addr(mem_addr, exp_addr.pop_front());
		end
	end

	// ------------------------------
	// main sequence
	// ------------------------------
	initial
	begin
		int vm;
		int k;
		int lerr;
		void'($urandom(61161));
		line_start = 1'b1;
		pre_vline  = 1'b1;	// first line is vline 0
		cfg_we     = 1'b0;
		cfg_addr   = '0;
		cfg_data   = '0;
		mem_data   = '0;
		mem_strobe = 1'b0;
		build_scene();
		repeat (8) @(posedge clk);
		line_start <= 1'b0;

		// line 0 loads the tables, not checked
		for (int s = 0; s < NSPR; s++)
			for (int r = 0; r < 8; r++)
				cfg_write(9'(s * 8 + r), attr[s][r]);
		for (int i = 0; i < 256; i++)
			cfg_write({1'b1, 8'(i)}, {1'b0, pal[i]});
		@(posedge clk);
		cfg_we <= 1'b0;
		wait_idle(0);

		vm = 0;
		for (int n = 1; n < NLINES && !hung; n++)
		begin
			prev_line = cur_line;
			vm = (n == RESTART_N) ? 0 : vm + 1;
			exp_addr.delete();
			render_line(vm);
			addr_en = 1'b1;
			@(posedge clk);
			line_start <= 1'b1;
			pre_vline  <= (n == RESTART_N);
			@(posedge clk);
			line_start <= 1'b0;
			lerr = errors;
			k = 0;
			for (int c = 1; c <= 4 * LINE_PIXELS + 2; c++)
			begin
				@(posedge clk);
				if (c >= 2 && (c - 2) % 4 == 0 && k < LINE_PIXELS)
				begin
					@(negedge clk);	// pixel k holds four clocks from here
					if (n >= 2)
						compare_pixel(k, pix_valid, pix_color, prev_line[k]);
					k++;
				end
			end
			wait_idle(n);
			if (exp_addr.size() != 0)
			begin
				errors++;
				$display("[ERROR] %0t %0d expected memory requests never came",
					$time, exp_addr.size());
			end
			tests++;
			$display("line %0d vline %0d: %s", n, vm, (errors == lerr) ? "ok" : "mismatch");
		end

		$display("tests %0d checks %0d errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
